// File: common/vdc_pkg.sv
// Shared types and register numbers for the 80-column video controller.
// Only the register subset that the controller implements has an index here.
`default_nettype none

package vdc_pkg;

	typedef logic [7:0]  byte_t;       // CPU bus and register byte
	typedef logic [15:0] vram_addr_t;  // Full video RAM address
	typedef logic [5:0]  reg_idx_t;    // Register select latch
	typedef logic [3:0]  rgbi_t;       // Colour, IRGB order

	// Encoding matches the version bits of the status byte
	typedef enum logic [1:0] {
		ver_8563r7a = 2'd0,
		ver_8563r9  = 2'd1,
		ver_8568    = 2'd2
	} vdc_version_e;

	localparam reg_idx_t reg_ht_idx    = 6'd0;   // Horizontal total
	localparam reg_idx_t reg_hd_idx    = 6'd1;   // Horizontal displayed
	localparam reg_idx_t reg_hp_idx    = 6'd2;   // Hsync position
	localparam reg_idx_t reg_sw_idx    = 6'd3;   // Sync widths, vw high nibble
	localparam reg_idx_t reg_vt_idx    = 6'd4;   // Vertical total
	localparam reg_idx_t reg_vd_idx    = 6'd6;   // Vertical displayed
	localparam reg_idx_t reg_vp_idx    = 6'd7;   // Vsync position
	localparam reg_idx_t reg_ctv_idx   = 6'd9;   // Scan lines per row minus 1
	localparam reg_idx_t reg_ds_hi_idx = 6'd12;  // Display start
	localparam reg_idx_t reg_ds_lo_idx = 6'd13;
	localparam reg_idx_t reg_ua_hi_idx = 6'd18;  // Update address
	localparam reg_idx_t reg_ua_lo_idx = 6'd19;
	localparam reg_idx_t reg_col_idx   = 6'd26;  // Fg high nibble, bg low nibble
	localparam reg_idx_t reg_cb_idx    = 6'd28;  // Character set base, bits 7:5
	localparam reg_idx_t reg_data_idx  = 6'd31;  // RAM data port
	localparam reg_idx_t reg_pol_idx   = 6'd37;  // Sync polarity, 8568 only

endpackage

`default_nettype wire

// File: vdc_regs/vdc_regs.sv
// CPU bus port and register file.
// Bus strobes are single cycle, no wait states; poll ready before R31 accesses.
// Unused register bits read back as 1, missing registers as 0xFF.
`timescale 1ns/1ps
`default_nettype none

module vdc_regs
	import vdc_pkg::*;
(
	input  wire               clk,
	input  wire               reset,
	input  wire vdc_version_e version,
	input  wire               cs,
	input  wire               rs,           // 0 address/status, 1 data
	input  wire               we,
	input  wire               bus_en,
	input  wire byte_t        db_in,
	output byte_t             db_out,
	output byte_t             ht,
	output byte_t             hd,
	output byte_t             hp,
	output byte_t             vt,
	output byte_t             vd,
	output byte_t             vp,
	output logic [3:0]        hw,
	output logic [3:0]        vw,
	output logic [4:0]        ctv,
	output vram_addr_t        ds,
	output logic [2:0]        cb,
	output rgbi_t             fg,
	output rgbi_t             bg,
	output logic              hs_pol,
	output logic              vs_pol,
	output logic              ua_load,
	output vram_addr_t        ua_value,
	output logic              data_write,
	output logic              data_read,
	output byte_t             data_value,
	input  wire vram_addr_t   ua_cur,
	input  wire byte_t        data_prefetch,
	input  wire               busy,
	input  wire               vblank
);

	reg_idx_t   reg_sel;   // Selected register
	logic       wr_strobe;
	logic       rd_strobe;
	logic       is_8568;
	vram_addr_t ua_now;    // Update address including a load still in flight
	byte_t      read_val;
	byte_t      status;

	assign wr_strobe = bus_en && cs && we;
	assign rd_strobe = bus_en && cs && !we;
	assign is_8568   = (version == ver_8568);
	assign ua_now    = ua_load ? ua_value : ua_cur;
	assign status    = {~busy, 1'b0, vblank, 3'b000, version};  // Ready, vblank, version

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_sel    <= '0;
			ht         <= '0;
			hd         <= '0;
			hp         <= '0;
			vt         <= '0;
			vd         <= '0;
			vp         <= '0;
			hw         <= '0;
			vw         <= '0;
			ctv        <= '0;
			ds         <= '0;
			cb         <= '0;
			fg         <= '0;
			bg         <= '0;
			hs_pol     <= 1'b0;
			vs_pol     <= 1'b0;
			ua_load    <= 1'b0;
			ua_value   <= '0;
			data_write <= 1'b0;
			data_read  <= 1'b0;
			data_value <= '0;
		end else begin
			ua_load    <= 1'b0;  // Strobes last one clock
			data_write <= 1'b0;
			data_read  <= 1'b0;
			if (wr_strobe && !rs) begin
				reg_sel <= db_in[5:0];
			end else if (wr_strobe) begin
				case (reg_sel)
					reg_ht_idx:    ht <= db_in;
					reg_hd_idx:    hd <= db_in;
					reg_hp_idx:    hp <= db_in;
					reg_sw_idx: begin
						vw <= db_in[7:4];
						hw <= db_in[3:0];
					end
					reg_vt_idx:    vt <= db_in;
					reg_vd_idx:    vd <= db_in;
					reg_vp_idx:    vp <= db_in;
					reg_ctv_idx:   ctv <= db_in[4:0];
					reg_ds_hi_idx: ds[15:8] <= db_in;
					reg_ds_lo_idx: ds[7:0] <= db_in;
					reg_ua_hi_idx: begin
						ua_load  <= 1'b1;
						ua_value <= {db_in, ua_now[7:0]};
					end
					reg_ua_lo_idx: begin
						ua_load  <= 1'b1;
						ua_value <= {ua_now[15:8], db_in};
					end
					reg_col_idx: begin
						fg <= db_in[7:4];
						bg <= db_in[3:0];
					end
					reg_cb_idx:    cb <= db_in[7:5];
					reg_data_idx: begin
						data_write <= 1'b1;  // RAM side drops it while busy
						data_value <= db_in;
					end
					reg_pol_idx: begin
						if (is_8568) begin
							hs_pol <= db_in[7];
							vs_pol <= db_in[6];
						end
					end
					default: ;
				endcase
			end
			if (rd_strobe && rs && (reg_sel == reg_data_idx))
				data_read <= 1'b1;  // Advance after the prefetched byte is taken
		end
	end

	always_comb begin
		case (reg_sel)
			reg_ht_idx:    read_val = ht;
			reg_hd_idx:    read_val = hd;
			reg_hp_idx:    read_val = hp;
			reg_sw_idx:    read_val = {vw, hw};
			reg_vt_idx:    read_val = vt;
			reg_vd_idx:    read_val = vd;
			reg_vp_idx:    read_val = vp;
			reg_ctv_idx:   read_val = {3'b111, ctv};
			reg_ds_hi_idx: read_val = ds[15:8];
			reg_ds_lo_idx: read_val = ds[7:0];
			reg_ua_hi_idx: read_val = ua_cur[15:8];
			reg_ua_lo_idx: read_val = ua_cur[7:0];
			reg_col_idx:   read_val = {fg, bg};
			reg_cb_idx:    read_val = {cb, 5'b11111};
			reg_data_idx:  read_val = data_prefetch;  // Byte at update address
			reg_pol_idx:   read_val = is_8568 ? {hs_pol, vs_pol, 6'b111111} : 8'hff;
			default:       read_val = 8'hff;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			db_out <= '0;
		else if (rd_strobe)
			db_out <= rs ? read_val : status;  // Held until the next read
	end

endmodule

`default_nettype wire

// File: source/vdc_timing.sv
// Raster timing from the register values, 8 pixel wide cells.
// Totals are compared with >=, so shrinking a total mid-frame wraps cleanly.
`timescale 1ns/1ps
`default_nettype none

module vdc_timing
	import vdc_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  wire        pixel_en,
	input  wire byte_t ht,
	input  wire byte_t hd,
	input  wire byte_t hp,
	input  wire [3:0]  hw,
	input  wire byte_t vt,
	input  wire byte_t vd,
	input  wire byte_t vp,
	input  wire [3:0]  vw,
	input  wire [4:0]  ctv,
	output logic       col_start,
	output byte_t      char_col,
	output byte_t      row,
	output logic [4:0] scan_line,
	output logic       display_en,
	output logic       hsync_raw,
	output logic       vsync_raw,
	output logic       hblank,
	output logic       vblank
);

	logic [2:0] pix;         // Pixel within cell
	logic [3:0] vs_cnt;      // Vsync lines left
	logic       line_start;
	logic [8:0] hs_end;      // One past the last hsync cell

	assign col_start  = pixel_en && (pix == 3'd0);
	assign line_start = col_start && (char_col == 8'd0);
	assign display_en = (char_col < hd) && (row < vd);
	assign hs_end     = {1'b0, hp} + {5'd0, hw};
	assign vsync_raw  = (vs_cnt != 4'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			pix       <= '0;
			char_col  <= '0;
			scan_line <= '0;
			row       <= '0;
		end else if (pixel_en) begin
			pix <= pix + 3'd1;
			if (pix == 3'd7) begin
				if (char_col >= ht) begin          // End of line
					char_col <= '0;
					if (scan_line >= ctv) begin    // End of row
						scan_line <= '0;
						row       <= (row >= vt) ? 8'd0 : row + 8'd1;
					end else begin
						scan_line <= scan_line + 5'd1;
					end
				end else begin
					char_col <= char_col + 8'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hsync_raw <= 1'b0;
			hblank    <= 1'b0;
			vblank    <= 1'b0;
			vs_cnt    <= '0;
		end else if (pixel_en) begin
			hblank    <= (char_col >= hd);
			vblank    <= (row >= vd);
			hsync_raw <= (char_col >= hp) && ({1'b0, char_col} < hs_end);
			if (line_start) begin
				if ((row == vp) && (scan_line == 5'd0))
					vs_cnt <= vw;                  // May run on into the next row
				else if (vs_cnt != 4'd0)
					vs_cnt <= vs_cnt - 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/vdc_vram.sv
// Video RAM with one shared port: a display fetch takes any cycle it wants,
// CPU accesses wait for a free one. Addresses wrap to ram_addr_width bits.
// Data strobes that arrive while busy are dropped.
`timescale 1ns/1ps
`default_nettype none

module vdc_vram
	import vdc_pkg::*;
#(
	parameter int ram_addr_width = 16   // 14 for 16K, 16 for 64K
)(
	input  wire             clk,
	input  wire             reset,
	input  wire             ua_load,
	input  wire vram_addr_t ua_value,
	input  wire             data_write,
	input  wire             data_read,
	input  wire byte_t      data_value,
	output vram_addr_t      ua_cur,
	output byte_t           data_prefetch,
	output logic            busy,
	input  wire             fetch_req,
	input  wire vram_addr_t fetch_addr,
	output byte_t           fetch_data     // Two clocks after fetch_req
);

	localparam vram_addr_t addr_mask = vram_addr_t'((32'd1 << ram_addr_width) - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_write,     // Waiting for a free cycle to store
		st_prefetch,  // Waiting for a free cycle to read
		st_capture    // Read data on rd_q
	} cpu_state_e;

	byte_t mem [0:(1 << ram_addr_width) - 1];

	cpu_state_e                state;
	byte_t                     wr_data;
	byte_t                     rd_q;
	logic                      cpu_grant;
	logic [ram_addr_width-1:0] port_addr;

	assign busy      = (state != st_idle);
	assign cpu_grant = !fetch_req && ((state == st_write) || (state == st_prefetch));
	assign port_addr = fetch_req ? fetch_addr[ram_addr_width-1:0] : ua_cur[ram_addr_width-1:0];

	always_ff @(posedge clk) begin
		if (cpu_grant && (state == st_write))
			mem[port_addr] <= wr_data;
		rd_q       <= mem[port_addr];
		fetch_data <= rd_q;                   // Second stage of display read
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= st_idle;
			ua_cur        <= '0;
			data_prefetch <= '0;
		end else if (ua_load) begin
			ua_cur <= ua_value & addr_mask;
			state  <= st_prefetch;
		end else begin
			case (state)
				st_idle: begin
					if (data_write) begin
						wr_data <= data_value;
						state   <= st_write;
					end else if (data_read) begin
						ua_cur <= (ua_cur + 16'd1) & addr_mask;
						state  <= st_prefetch;
					end
				end
				st_write: begin
					if (cpu_grant) begin
						ua_cur <= (ua_cur + 16'd1) & addr_mask;
						state  <= st_prefetch;
					end
				end
				st_prefetch: begin
					if (cpu_grant)
						state <= st_capture;
				end
				default: begin
					data_prefetch <= rd_q;
					state         <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/vdc_render.sv
// Text renderer, one cell ahead: screen code, then glyph, then shifter.
// Pixels and blanking come out one cell (8 pixel_en strobes) late.
// Both fetches must finish within 8 clocks; pixel_en at most every clock.
`timescale 1ns/1ps
`default_nettype none

module vdc_render
	import vdc_pkg::*;
(
	input  wire             clk,
	input  wire             reset,
	input  wire             pixel_en,
	input  wire             col_start,
	input  wire byte_t      char_col,
	input  wire byte_t      row,
	input  wire [4:0]       scan_line,
	input  wire             display_en,
	input  wire             hblank_in,
	input  wire             vblank_in,
	input  wire byte_t      hd,
	input  wire vram_addr_t ds,
	input  wire [2:0]       cb,
	input  wire rgbi_t      fg,
	input  wire rgbi_t      bg,
	output logic            fetch_req,
	output vram_addr_t      fetch_addr,
	input  wire byte_t      fetch_data,
	output rgbi_t           rgbi,
	output logic            hblank,
	output logic            vblank
);

	logic [1:0] code_pipe;   // Screen code fetch in flight
	logic [1:0] glyph_pipe;  // Glyph fetch in flight
	logic       code_req;
	logic       glyph_req;
	logic [4:0] line_q;      // Scan line of the fetched cell
	vram_addr_t scr_addr;
	vram_addr_t glyph_addr;
	byte_t      glyph_next;  // Pattern for the next cell
	byte_t      shift_q;
	logic [7:0] hb_pipe;
	logic [7:0] vb_pipe;

	assign code_req   = col_start && display_en;
	assign glyph_req  = code_pipe[1];             // Code is on fetch_data now
	assign fetch_req  = code_req || glyph_req;
	assign scr_addr   = ds + vram_addr_t'(row * hd) + vram_addr_t'(char_col);
	assign glyph_addr = {cb, 13'd0} + {4'd0, fetch_data, 4'd0} + vram_addr_t'(line_q);
	assign fetch_addr = glyph_req ? glyph_addr : scr_addr;
	assign hblank     = hb_pipe[7];
	assign vblank     = vb_pipe[7];
	assign rgbi       = (hblank || vblank) ? 4'd0 : (shift_q[7] ? fg : bg);

	always_ff @(posedge clk) begin
		if (reset) begin
			code_pipe  <= '0;
			glyph_pipe <= '0;
		end else begin
			code_pipe  <= {code_pipe[0], code_req};
			glyph_pipe <= {glyph_pipe[0], glyph_req};
		end
	end

	always_ff @(posedge clk) begin
		if (col_start) begin
			line_q <= scan_line;
			if (!display_en)
				glyph_next <= '0;                     // Border cell shows bg
		end
		if (glyph_pipe[1])
			glyph_next <= fetch_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			shift_q <= '0;
			hb_pipe <= '0;
			vb_pipe <= '0;
		end else if (pixel_en) begin
			shift_q <= col_start ? glyph_next : {shift_q[6:0], 1'b0};  // MSB first
			hb_pipe <= {hb_pipe[6:0], hblank_in};
			vb_pipe <= {vb_pipe[6:0], vblank_in};
		end
	end

endmodule

`default_nettype wire

// File: source/vdc_top.sv
// 80-column text controller, top level.
// Sync polarity from R37 only applies on the 8568; other versions are active high.
`timescale 1ns/1ps
`default_nettype none

module vdc_top
	import vdc_pkg::*;
#(
	parameter int ram_addr_width = 16   // 14 or 16
)(
	input  wire               clk,
	input  wire               reset,
	input  wire vdc_version_e version,
	input  wire               cs,
	input  wire               rs,
	input  wire               we,
	input  wire               bus_en,
	input  wire byte_t        db_in,
	output byte_t             db_out,
	input  wire               pixel_en,
	output logic              hsync,
	output logic              vsync,
	output logic              hblank,
	output logic              vblank,
	output rgbi_t             rgbi
);

	byte_t      ht, hd, hp, vt, vd, vp;
	logic [3:0] hw, vw;
	logic [4:0] ctv;
	vram_addr_t ds;
	logic [2:0] cb;
	rgbi_t      fg, bg;
	logic       hs_pol, vs_pol;
	logic       ua_load, data_write, data_read, busy;
	vram_addr_t ua_value, ua_cur;
	byte_t      data_value, data_prefetch;
	logic       col_start, display_en;
	byte_t      char_col, row;
	logic [4:0] scan_line;
	logic       hsync_raw, vsync_raw, hblank_raw, vblank_raw;
	logic       fetch_req;
	vram_addr_t fetch_addr;
	byte_t      fetch_data;
	logic       is_8568;

	assign is_8568 = (version == ver_8568);
	assign hsync   = hsync_raw ^ (is_8568 && hs_pol);  // Inverted pulse when set
	assign vsync   = vsync_raw ^ (is_8568 && vs_pol);

	vdc_regs u_regs (
		.*,
		.vblank(vblank_raw)                   // Status bit uses the raw raster
	);

	vdc_timing u_timing (
		.*,
		.hblank(hblank_raw),
		.vblank(vblank_raw)
	);

	vdc_vram #(
		.ram_addr_width(ram_addr_width)
	) u_vram (
		.*
	);

	vdc_render u_render (
		.*,
		.hblank_in(hblank_raw),
		.vblank_in(vblank_raw)
	);

endmodule

`default_nettype wire

// File: test/vdc_tb.sv
// Directed testbench for the 80-column controller with 64K RAM and the 8568 version.
// Geometry is shrunk so one frame is 3200 clocks with pixel_en held high.
// R31 accesses poll the ready bit first, as a host CPU must.
`timescale 1ns/1ps
`default_nettype none

module vdc_tb
	import vdc_pkg::*;
();

	localparam int timeout_clks = 20000;                       // Per wait loop
	localparam int ht_val       = 9;
	localparam int hd_val       = 4;
	localparam int hp_val       = 6;
	localparam int hw_val       = 2;                           // Hsync cells
	localparam int vw_val       = 1;                           // Vsync scan lines
	localparam int vt_val       = 4;
	localparam int vd_val       = 2;
	localparam int vp_val       = 3;
	localparam int ctv_val      = 7;
	localparam int line_clks    = (ht_val + 1) * 8;
	localparam int frame_clks   = line_clks * (ctv_val + 1) * (vt_val + 1);
	localparam int disp_pix     = hd_val * 8 * (ctv_val + 1) * vd_val;
	localparam rgbi_t fg_val    = 4'ha;
	localparam rgbi_t bg_val    = 4'h5;
	localparam vram_addr_t glyph1_addr = 16'h2010;             // Code 1 in character set 1

	logic         clk;
	logic         reset;
	vdc_version_e version;
	logic         cs;
	logic         rs;
	logic         we;
	logic         bus_en;
	byte_t        db_in;
	byte_t        db_out;
	logic         pixel_en;
	logic         hsync;
	logic         vsync;
	logic         hblank;
	logic         vblank;
	rgbi_t        rgbi;

	vdc_top #(
		.ram_addr_width(16)
	) dut (
		.*
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;                                   // 4 ns period
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp)
			stop_run($sformatf("Error %s: expected 0x%h, actual 0x%h", name, exp, act));
	endtask

	task automatic check_rgbi(input string name, input rgbi_t exp, input rgbi_t act);
		if (act !== exp)
			stop_run($sformatf("Error %s: expected 0x%h, actual 0x%h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("Error %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			stop_run($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// Bits with no storage behind them read back as 1
	function automatic byte_t unused_bits(input reg_idx_t idx);
		case (idx)
			reg_ctv_idx: return 8'he0;                             // 5-bit count
			reg_cb_idx:  return 8'h1f;                             // Base in 7:5
			reg_pol_idx: return 8'h3f;                             // Polarity in 7:6
			default:     return 8'h00;
		endcase
	endfunction

	// One strobe with inputs changed 1 ns after the edge
	task automatic bus_cycle(input logic rs_v, input logic we_v, input byte_t data);
		cs     = 1'b1;
		rs     = rs_v;
		we     = we_v;
		db_in  = data;
		bus_en = 1'b1;
		@(posedge clk);
		#1;
		bus_en = 1'b0;
		cs     = 1'b0;
	endtask

	task automatic bus_write_reg(input reg_idx_t idx, input byte_t val);
		bus_cycle(1'b0, 1'b1, byte_t'(idx));                     // Select latch
		bus_cycle(1'b1, 1'b1, val);
	endtask

	task automatic bus_read_reg(input reg_idx_t idx, output byte_t val);
		bus_cycle(1'b0, 1'b1, byte_t'(idx));
		bus_cycle(1'b1, 1'b0, 8'h00);
		val = db_out;                                            // Registered at the strobe
	endtask

	task automatic read_status(output byte_t val);
		bus_cycle(1'b0, 1'b0, 8'h00);
		val = db_out;
	endtask

	task automatic wait_ready();
		byte_t st;
		int    n;
		n = 0;
		repeat (2) begin                                         // Strobe reaches busy late
			@(posedge clk);
			#1;
		end
		read_status(st);
		while (!st[7]) begin
			n++;
			if (n > timeout_clks)
				stop_run("Timeout: the RAM interface never became ready");
			read_status(st);
		end
	endtask

	// Counts clocks until hsync (which 0) or vsync (which 1) reaches level
	task automatic wait_level(input int which, input logic level, output int n);
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
			if (n > timeout_clks)
				stop_run($sformatf("Timeout: %s never went to %0d",
					(which != 0) ? "vsync" : "hsync", level));
		end while (((which != 0) ? vsync : hsync) !== level);
	endtask

	task automatic set_update_addr(input vram_addr_t addr);
		bus_write_reg(reg_ua_hi_idx, addr[15:8]);
		bus_write_reg(reg_ua_lo_idx, addr[7:0]);
	endtask

	task automatic write_vram(input byte_t val);
		wait_ready();
		bus_write_reg(reg_data_idx, val);
	endtask

	task automatic read_vram(output byte_t val);
		wait_ready();
		bus_read_reg(reg_data_idx, val);                         // Byte before the increment
	endtask

	task automatic check_update_addr(input string name, input vram_addr_t exp);
		byte_t hi;
		byte_t lo;
		wait_ready();
		bus_read_reg(reg_ua_hi_idx, hi);
		bus_read_reg(reg_ua_lo_idx, lo);
		check_byte({name, " R18"}, exp[15:8], hi);
		check_byte({name, " R19"}, exp[7:0], lo);
	endtask

	task automatic set_geometry();
		bus_write_reg(reg_pol_idx, 8'h00);                       // Active high sync
		bus_write_reg(reg_ht_idx, byte_t'(ht_val));
		bus_write_reg(reg_hd_idx, byte_t'(hd_val));
		bus_write_reg(reg_hp_idx, byte_t'(hp_val));
		bus_write_reg(reg_sw_idx, byte_t'((vw_val << 4) | hw_val));
		bus_write_reg(reg_vt_idx, byte_t'(vt_val));
		bus_write_reg(reg_vd_idx, byte_t'(vd_val));
		bus_write_reg(reg_vp_idx, byte_t'(vp_val));
		bus_write_reg(reg_ctv_idx, byte_t'(ctv_val));
	endtask

	task automatic fill_glyph(input byte_t pattern);
		set_update_addr(glyph1_addr);
		repeat (16) write_vram(pattern);                         // All 16 scan lines
		wait_ready();
	endtask

	// One whole frame of samples after a vsync pulse
	task automatic sample_frame(input string name, input rgbi_t exp);
		int n;
		int n_disp;
		wait_level(1, 1'b1, n);
		wait_level(1, 1'b0, n);                                  // Display rows come next
		n_disp = 0;
		repeat (frame_clks) begin
			@(posedge clk);
			#1;
			if (hblank || vblank) begin
				check_rgbi({name, " blank"}, 4'h0, rgbi);
			end else begin
				n_disp++;
				check_rgbi(name, exp, rgbi);
			end
		end
		check_count({name, " displayed pixels"}, disp_pix, n_disp);
	endtask

	task automatic test_reg_readback();
		reg_idx_t impl [15];
		reg_idx_t missing [6];
		byte_t    val [15];
		byte_t    rd;
		impl = '{reg_ht_idx, reg_hd_idx, reg_hp_idx, reg_sw_idx, reg_vt_idx, reg_vd_idx,
			reg_vp_idx, reg_ctv_idx, reg_ds_hi_idx, reg_ds_lo_idx, reg_ua_hi_idx,
			reg_ua_lo_idx, reg_col_idx, reg_cb_idx, reg_pol_idx};
		missing = '{6'd5, 6'd8, 6'd10, 6'd20, 6'd36, 6'd63};
		foreach (impl[i]) begin
			val[i] = byte_t'($urandom);
			bus_write_reg(impl[i], val[i]);
		end
		foreach (impl[i]) begin                                  // Read after all writes
			bus_read_reg(impl[i], rd);
			check_byte($sformatf("readback R%0d", impl[i]), val[i] | unused_bits(impl[i]), rd);
		end
		foreach (missing[i]) begin
			bus_read_reg(missing[i], rd);
			check_byte($sformatf("unimplemented R%0d", missing[i]), 8'hff, rd);
		end
		read_status(rd);
		check_byte("status version", byte_t'(version), rd & 8'h03);
	endtask

	task automatic test_vram_access();
		vram_addr_t start;
		byte_t      data [16];
		byte_t      rd;
		start = vram_addr_t'($urandom);
		set_update_addr(start);
		foreach (data[i]) begin
			data[i] = byte_t'($urandom);
			write_vram(data[i]);
		end
		check_update_addr("vram after writes", start + 16'd16);
		set_update_addr(start);
		foreach (data[i]) begin
			read_vram(rd);
			check_byte($sformatf("vram byte %0d", i), data[i], rd);
		end
		check_update_addr("vram after reads", start + 16'd16);
	endtask

	task automatic test_hsync_timing();
		int n;
		int n_high;
		int n_low;
		set_geometry();
		wait_level(0, 1'b0, n);
		wait_level(0, 1'b1, n);                                  // Rising edge
		wait_level(0, 1'b0, n_high);
		wait_level(0, 1'b1, n_low);
		check_count("hsync width", hw_val * 8, n_high);
		check_count("hsync period", line_clks, n_high + n_low);
	endtask

	task automatic test_sync_polarity();
		int n;
		int n_high;
		int n_low;
		bus_write_reg(reg_pol_idx, 8'hc0);                       // Both syncs inverted
		wait_level(0, 1'b1, n);
		wait_level(0, 1'b0, n);                                  // Pulse starts low
		wait_level(0, 1'b1, n_low);
		wait_level(0, 1'b0, n_high);
		check_count("hsync low pulse", hw_val * 8, n_low);
		check_count("hsync high idle", line_clks - hw_val * 8, n_high);
		wait_level(1, 1'b1, n);
		wait_level(1, 1'b0, n);
		wait_level(1, 1'b1, n_low);
		wait_level(1, 1'b0, n_high);
		check_count("vsync low pulse", vw_val * line_clks, n_low);
		check_count("vsync high idle", frame_clks - vw_val * line_clks, n_high);
		bus_write_reg(reg_pol_idx, 8'h00);
	endtask

	task automatic test_pixel_output();
		bus_write_reg(reg_ds_hi_idx, 8'h00);                     // Screen at 0
		bus_write_reg(reg_ds_lo_idx, 8'h00);
		bus_write_reg(reg_cb_idx, 8'h20);                        // Glyphs at 0x2000
		bus_write_reg(reg_col_idx, {fg_val, bg_val});
		set_update_addr(16'h0000);
		repeat (hd_val * vd_val) write_vram(8'h01);              // Code 1 in each cell
		fill_glyph(8'hff);
		sample_frame("pixel fg", fg_val);
		fill_glyph(8'h00);
		sample_frame("pixel bg", bg_val);
	endtask

	initial begin
		void'($urandom(54));
		reset    = 1'b1;
		version  = ver_8568;
		cs       = 1'b0;
		rs       = 1'b0;
		we       = 1'b0;
		bus_en   = 1'b0;
		db_in    = 8'h00;
		pixel_en = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		check_byte("reset db_out", 8'h00, db_out);
		check_bit("reset hsync", 1'b0, hsync);                   // Outputs still hold reset state
		check_bit("reset vsync", 1'b0, vsync);
		check_bit("reset hblank", 1'b0, hblank);
		check_bit("reset vblank", 1'b0, vblank);
		check_rgbi("reset rgbi", 4'h0, rgbi);
		test_reg_readback();
		test_vram_access();
		test_hsync_timing();
		test_sync_polarity();
		test_pixel_output();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: vdc_top.f
common/vdc_pkg.sv
vdc_regs/vdc_regs.sv
source/vdc_timing.sv
source/vdc_vram.sv
source/vdc_render.sv
source/vdc_top.sv
test/vdc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run vdc_tb with Verilator; exits non-zero on any failure.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --timescale 1ns/1ps -f vdc_top.f --top-module vdc_tb \
	-Mdir obj_dir -o vdc_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi
./obj_dir/vdc_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0
